//--- hdl/periph_pkg.sv
/*
 * shared bus widths, vector types and register map of the peripheral block
 * word address: top 2 bits pick the peripheral, low 2 bits the register
 * peripheral selects 2 and 3 are unmapped and read back as zero
 * byte selects are not decoded, every write replaces a whole register
 */
package periph_pkg;

	// --------------------
	// bus
	// --------------------
	localparam int WB_ADR_WIDTH = 4;
	localparam int WB_DAT_WIDTH = 32;

	typedef logic [WB_ADR_WIDTH-1:0] wb_adr_t;
	typedef logic [WB_DAT_WIDTH-1:0] wb_dat_t;

	// register index inside one peripheral
	typedef logic [1:0] reg_sel_t;

	// --------------------
	// peripheral map
	// --------------------
	localparam logic [1:0] PERIPH_GPIO  = 2'd0;
	localparam logic [1:0] PERIPH_TIMER = 2'd1;

	// gpio registers, index 3 reads zero
	localparam reg_sel_t GPIO_ADR_DIRECTION = 2'd0;
	localparam reg_sel_t GPIO_ADR_INPUT     = 2'd1;
	localparam reg_sel_t GPIO_ADR_OUTPUT    = 2'd2;

	// timer registers
	localparam reg_sel_t TMR_ADR_CONTROL = 2'd0;
	localparam reg_sel_t TMR_ADR_RELOAD  = 2'd1;
	localparam reg_sel_t TMR_ADR_COUNT   = 2'd2;
	localparam reg_sel_t TMR_ADR_STATUS  = 2'd3;

	// --------------------
	// timer control bits
	// --------------------
	localparam int TMR_CTL_ENABLE = 0;
	localparam int TMR_CTL_IRQ_EN = 1;

endpackage

//--- hdl/periph_wb_decode.sv
/*
 * address decoder for the single Wishbone slave port
 * acknowledge follows the strobe in the same cycle, no wait states
 * read data is merged by peripheral select, unmapped space reads zero
 */
`timescale 1ns/100ps

module periph_wb_decode
	import periph_pkg::*;
(
	// bus side
	input  wb_adr_t  wb_adr_i,
	input  logic     wb_stb_i,
	output wb_dat_t  wb_dat_o,
	output logic     wb_ack_o,

	// peripheral side
	input  wb_dat_t  gpio_rdata_i,
	input  wb_dat_t  tmr_rdata_i,
	output logic     gpio_stb_o,
	output logic     tmr_stb_o,
	output reg_sel_t reg_sel_o
);

	logic [1:0] periph_sel;

	// --------------------
	// address split
	// --------------------
	assign periph_sel = wb_adr_i[WB_ADR_WIDTH-1 -: 2];
	assign reg_sel_o  = wb_adr_i[1:0];

	// one strobe per peripheral
	assign gpio_stb_o = wb_stb_i && (periph_sel == PERIPH_GPIO);
	assign tmr_stb_o  = wb_stb_i && (periph_sel == PERIPH_TIMER);

	// every cycle completes at once
	assign wb_ack_o = wb_stb_i;

	// --------------------
	// read data merge
	// --------------------
	always_comb begin
		case (periph_sel)
			PERIPH_GPIO: begin
				wb_dat_o = gpio_rdata_i;
			end
			PERIPH_TIMER: begin
				wb_dat_o = tmr_rdata_i;
			end
			default: begin
				wb_dat_o = '0;
			end
		endcase
	end

	// at most one peripheral strobe at a time
	always_comb begin
		strobes_exclusive: assert (!(gpio_stb_o && tmr_stb_o))
			else $error("gpio and timer strobes high together");
	end

endmodule

//--- hdl/periph_gpio.sv
/*
 * general purpose port with direction, input and output registers
 * PORT_WIDTH is 1 to 32, reads are zero-extended to the bus width
 * no pads here: gpio_oe_o high means the pin drives gpio_o
 * the input register samples gpio_i every clock and clears on reset
 */
`timescale 1ns/100ps

module periph_gpio
	import periph_pkg::*;
#(
	parameter int unsigned           PORT_WIDTH     = 8,
	parameter logic [PORT_WIDTH-1:0] INIT_DIRECTION = '0,
	parameter logic [PORT_WIDTH-1:0] INIT_OUTPUT    = '0
) (
	input  logic                  clk,
	input  logic                  reset,

	// register access from the decoder
	input  logic                  stb_i,
	input  logic                  we_i,
	input  reg_sel_t              reg_sel_i,
	input  wb_dat_t               dat_i,
	output wb_dat_t               rdata_o,

	// pins
	input  logic [PORT_WIDTH-1:0] gpio_i,
	output logic [PORT_WIDTH-1:0] gpio_o,
	output logic [PORT_WIDTH-1:0] gpio_oe_o
);

	logic [PORT_WIDTH-1:0] direction_q;
	logic [PORT_WIDTH-1:0] input_q;
	logic [PORT_WIDTH-1:0] output_q;

	logic dir_wr;
	logic out_wr;

	// --------------------
	// register writes
	// --------------------
	assign dir_wr = stb_i && we_i && (reg_sel_i == GPIO_ADR_DIRECTION);
	assign out_wr = stb_i && we_i && (reg_sel_i == GPIO_ADR_OUTPUT);

	always_ff @(posedge clk) begin
		if (reset) begin
			direction_q <= INIT_DIRECTION;
			output_q    <= INIT_OUTPUT;
			input_q     <= '0;
		end else begin
			if (dir_wr) begin
				direction_q <= dat_i[PORT_WIDTH-1:0];
			end
			if (out_wr) begin
				output_q <= dat_i[PORT_WIDTH-1:0];
			end
			// pins sampled every clock, one cycle of latency
			input_q <= gpio_i;
		end
	end

	assign gpio_o    = output_q;
	assign gpio_oe_o = direction_q;

	// --------------------
	// read mux
	// --------------------
	always_comb begin
		rdata_o = '0;
		case (reg_sel_i)
			GPIO_ADR_DIRECTION: begin
				rdata_o[PORT_WIDTH-1:0] = direction_q;
			end
			GPIO_ADR_INPUT: begin
				rdata_o[PORT_WIDTH-1:0] = input_q;
			end
			GPIO_ADR_OUTPUT: begin
				rdata_o[PORT_WIDTH-1:0] = output_q;
			end
			default: begin
				rdata_o = '0;
			end
		endcase
	end

	// pin drivers only move after a direction write or a reset
	oe_follows_write: assert property (
		@(posedge clk) disable iff (reset)
		$changed(gpio_oe_o) |-> ($past(dir_wr) || $past(reset))
	) else $error("gpio_oe_o changed without a direction write");

endmodule

//--- hdl/periph_timer.sv
/*
 * down-counting interval timer with reload and a sticky expiry flag
 * TIMER_WIDTH is 1 to 32, the expiry period is reload plus one cycles
 * a reload write also loads the counter; the count register is read only
 * status write with bit 0 set clears the flag, a same-cycle expiry wins
 */
`timescale 1ns/100ps

module periph_timer
	import periph_pkg::*;
#(
	parameter int unsigned TIMER_WIDTH = 16
) (
	input  logic     clk,
	input  logic     reset,

	// register access from the decoder
	input  logic     stb_i,
	input  logic     we_i,
	input  reg_sel_t reg_sel_i,
	input  wb_dat_t  dat_i,
	output wb_dat_t  rdata_o,

	output logic     irq_o
);

	logic                   enable_q;
	logic                   irq_en_q;
	logic [TIMER_WIDTH-1:0] reload_q;
	logic [TIMER_WIDTH-1:0] count_q;
	logic                   expired_q;

	logic ctl_wr;
	logic reload_wr;
	logic status_wr;
	logic expire;

	assign ctl_wr    = stb_i && we_i && (reg_sel_i == TMR_ADR_CONTROL);
	assign reload_wr = stb_i && we_i && (reg_sel_i == TMR_ADR_RELOAD);
	assign status_wr = stb_i && we_i && (reg_sel_i == TMR_ADR_STATUS);

	// a reload write takes priority over the wrap
	assign expire = enable_q && !reload_wr && (count_q == '0);

	// --------------------
	// counter and flag
	// --------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			enable_q  <= 1'b0;
			irq_en_q  <= 1'b0;
			reload_q  <= '0;
			count_q   <= '0;
			expired_q <= 1'b0;
		end else begin
			if (ctl_wr) begin
				enable_q <= dat_i[TMR_CTL_ENABLE];
				irq_en_q <= dat_i[TMR_CTL_IRQ_EN];
			end

			if (reload_wr) begin
				reload_q <= dat_i[TIMER_WIDTH-1:0];
				count_q  <= dat_i[TIMER_WIDTH-1:0];
			end else if (expire) begin
				count_q <= reload_q;
			end else if (enable_q) begin
				count_q <= count_q - TIMER_WIDTH'(1);
			end

			// set beats clear
			if (expire) begin
				expired_q <= 1'b1;
			end else if (status_wr && dat_i[0]) begin
				expired_q <= 1'b0;
			end
		end
	end

	assign irq_o = expired_q && irq_en_q;

	// --------------------
	// read mux
	// --------------------
	always_comb begin
		rdata_o = '0;
		case (reg_sel_i)
			TMR_ADR_CONTROL: begin
				rdata_o[TMR_CTL_ENABLE] = enable_q;
				rdata_o[TMR_CTL_IRQ_EN] = irq_en_q;
			end
			TMR_ADR_RELOAD: begin
				rdata_o[TIMER_WIDTH-1:0] = reload_q;
			end
			TMR_ADR_COUNT: begin
				rdata_o[TIMER_WIDTH-1:0] = count_q;
			end
			default: begin
				// status, flag in bit 0
				rdata_o[0] = expired_q;
			end
		endcase
	end

	count_in_range: assert property (
		@(posedge clk) disable iff (reset)
		!reload_wr |-> (count_q <= reload_q)
	) else $error("timer count above reload value");

endmodule

//--- hdl/periph_top.sv
/*
 * peripheral block top: bus decoder, gpio port and interval timer
 * pads are split into gpio_i, gpio_o and gpio_oe_o, the tristate is outside
 * wb_sel_i is accepted but not decoded
 * PORT_WIDTH and TIMER_WIDTH are at most 32
 */
`timescale 1ns/100ps

module periph_top
	import periph_pkg::*;
#(
	parameter int unsigned           PORT_WIDTH     = 8,
	parameter int unsigned           TIMER_WIDTH    = 16,
	parameter logic [PORT_WIDTH-1:0] INIT_DIRECTION = '0,
	parameter logic [PORT_WIDTH-1:0] INIT_OUTPUT    = '0
) (
	input  logic                      clk,
	input  logic                      reset,

	// wishbone slave
	input  wb_adr_t                   wb_adr_i,
	input  wb_dat_t                   wb_dat_i,
	input  logic                      wb_we_i,
	input  logic [WB_DAT_WIDTH/8-1:0] wb_sel_i,
	input  logic                      wb_stb_i,
	output wb_dat_t                   wb_dat_o,
	output logic                      wb_ack_o,

	// port pins
	input  logic [PORT_WIDTH-1:0]     gpio_i,
	output logic [PORT_WIDTH-1:0]     gpio_o,
	output logic [PORT_WIDTH-1:0]     gpio_oe_o,

	output logic                      irq_o
);

	logic     gpio_stb;
	logic     tmr_stb;
	reg_sel_t reg_sel;
	wb_dat_t  gpio_rdata;
	wb_dat_t  tmr_rdata;

	// --------------------
	// bus decode
	// --------------------
	periph_wb_decode u_decode (
		.wb_adr_i     (wb_adr_i),
		.wb_stb_i     (wb_stb_i),
		.wb_dat_o     (wb_dat_o),
		.wb_ack_o     (wb_ack_o),
		.gpio_rdata_i (gpio_rdata),
		.tmr_rdata_i  (tmr_rdata),
		.gpio_stb_o   (gpio_stb),
		.tmr_stb_o    (tmr_stb),
		.reg_sel_o    (reg_sel)
	);

	// --------------------
	// peripherals
	// --------------------
	periph_gpio #(
		.PORT_WIDTH     (PORT_WIDTH),
		.INIT_DIRECTION (INIT_DIRECTION),
		.INIT_OUTPUT    (INIT_OUTPUT)
	) u_gpio (
		.clk       (clk),
		.reset     (reset),
		.stb_i     (gpio_stb),
		.we_i      (wb_we_i),
		.reg_sel_i (reg_sel),
		.dat_i     (wb_dat_i),
		.rdata_o   (gpio_rdata),
		.gpio_i    (gpio_i),
		.gpio_o    (gpio_o),
		.gpio_oe_o (gpio_oe_o)
	);

	periph_timer #(
		.TIMER_WIDTH (TIMER_WIDTH)
	) u_timer (
		.clk       (clk),
		.reset     (reset),
		.stb_i     (tmr_stb),
		.we_i      (wb_we_i),
		.reg_sel_i (reg_sel),
		.dat_i     (wb_dat_i),
		.rdata_o   (tmr_rdata),
		.irq_o     (irq_o)
	);

endmodule

//--- verif/tb_periph.sv
/*
 * testbench for periph_top with default parameters
 * random bus traffic and pad values from a fixed seed, checked every cycle
 * against a register model of the gpio port and the interval timer
 * inputs move 1 ns after the rising edge, outputs are checked at the falling edge
 */
`timescale 1ns/100ps

module tb_periph
	import periph_pkg::*;
;

	localparam int unsigned PORT_WIDTH     = 8;
	localparam int unsigned TIMER_WIDTH    = 16;
	localparam logic [PORT_WIDTH-1:0] INIT_DIRECTION = '0;
	localparam logic [PORT_WIDTH-1:0] INIT_OUTPUT    = '0;

	localparam int RESET_CYCLES = 16;
	localparam int NUM_CYCLES   = 4000;
	// reset plus random cycles, with margin
	localparam int TIMEOUT_CYCLES = 5000;
	localparam logic [31:0] SEED  = 32'h9e7d_42fc;

	typedef logic [PORT_WIDTH-1:0]  port_t;
	typedef logic [TIMER_WIDTH-1:0] count_t;

	logic      clk;
	logic      reset;
	wb_adr_t   wb_adr;
	wb_dat_t   wb_dat_w;
	logic      wb_we;
	logic [3:0] wb_sel;
	logic      wb_stb;
	wb_dat_t   wb_dat_r;
	logic      wb_ack;
	port_t     gpio_in;
	port_t     gpio_out;
	port_t     gpio_oe;
	logic      irq;

	// register model
	port_t  m_dir;
	port_t  m_in;
	port_t  m_out;
	logic   m_enable;
	logic   m_irq_en;
	logic   m_expired;
	count_t m_reload;
	count_t m_count;

	int cycle_count;

	periph_top dut0 (
		.clk       (clk),
		.reset     (reset),
		.wb_adr_i  (wb_adr),
		.wb_dat_i  (wb_dat_w),
		.wb_we_i   (wb_we),
		.wb_sel_i  (wb_sel),
		.wb_stb_i  (wb_stb),
		.wb_dat_o  (wb_dat_r),
		.wb_ack_o  (wb_ack),
		.gpio_i    (gpio_in),
		.gpio_o    (gpio_out),
		.gpio_oe_o (gpio_oe),
		.irq_o     (irq)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// --------------------
	// failure and compare
	// --------------------
	task automatic fail_run();
		$display("TESTS FAILED");
		$fatal(1, "simulation stopped at first error");
	endtask

	task automatic compare_dat(string what, wb_dat_t got, wb_dat_t exp);
		if (got !== exp) begin
			$display("MISMATCH at %0t: %s read %h, expected %h", $time, what, got, exp);
			fail_run();
		end
	endtask

	task automatic compare_port(string what, port_t got, port_t exp);
		if (got !== exp) begin
			$display("MISMATCH at %0t: %s is %h, expected %h", $time, what, got, exp);
			fail_run();
		end
	endtask

	task automatic compare_bit(string what, logic got, logic exp);
		if (got !== exp) begin
			$display("MISMATCH at %0t: %s is %b, expected %b", $time, what, got, exp);
			fail_run();
		end
	endtask

	always @(posedge clk) begin
		cycle_count = cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
			fail_run();
		end
	end

	// --------------------
	// model
	// --------------------
	function automatic wb_dat_t model_read(wb_adr_t adr);
		wb_dat_t d;
		d = '0;
		if (adr[3:2] == PERIPH_GPIO) begin
			case (adr[1:0])
				GPIO_ADR_DIRECTION: d[PORT_WIDTH-1:0] = m_dir;
				GPIO_ADR_INPUT:     d[PORT_WIDTH-1:0] = m_in;
				GPIO_ADR_OUTPUT:    d[PORT_WIDTH-1:0] = m_out;
				default:            d = '0;
			endcase
		end else if (adr[3:2] == PERIPH_TIMER) begin
			case (adr[1:0])
				TMR_ADR_CONTROL: begin
					d[TMR_CTL_ENABLE] = m_enable;
					d[TMR_CTL_IRQ_EN] = m_irq_en;
				end
				TMR_ADR_RELOAD: d[TIMER_WIDTH-1:0] = m_reload;
				TMR_ADR_COUNT:  d[TIMER_WIDTH-1:0] = m_count;
				default:        d[0] = m_expired;
			endcase
		end
		return d;
	endfunction

	// one clock of the register rules, from the inputs held at this edge
	task automatic step_model();
		logic     gpio_wr;
		logic     tmr_wr;
		logic     reload_wr;
		logic     expire;
		reg_sel_t idx;
		idx       = wb_adr[1:0];
		gpio_wr   = wb_stb && wb_we && (wb_adr[3:2] == PERIPH_GPIO);
		tmr_wr    = wb_stb && wb_we && (wb_adr[3:2] == PERIPH_TIMER);
		reload_wr = tmr_wr && (idx == TMR_ADR_RELOAD);
		expire    = m_enable && !reload_wr && (m_count == '0);

		if (reload_wr) begin
			m_reload = wb_dat_w[TIMER_WIDTH-1:0];
			m_count  = wb_dat_w[TIMER_WIDTH-1:0];
		end else if (expire) begin
			m_count = m_reload;
		end else if (m_enable) begin
			m_count = m_count - TIMER_WIDTH'(1);
		end

		if (expire) begin
			m_expired = 1'b1;
		end else if (tmr_wr && (idx == TMR_ADR_STATUS) && wb_dat_w[0]) begin
			m_expired = 1'b0;
		end

		if (tmr_wr && (idx == TMR_ADR_CONTROL)) begin
			m_enable = wb_dat_w[TMR_CTL_ENABLE];
			m_irq_en = wb_dat_w[TMR_CTL_IRQ_EN];
		end

		if (gpio_wr && (idx == GPIO_ADR_DIRECTION)) begin
			m_dir = wb_dat_w[PORT_WIDTH-1:0];
		end
		if (gpio_wr && (idx == GPIO_ADR_OUTPUT)) begin
			m_out = wb_dat_w[PORT_WIDTH-1:0];
		end
		m_in = gpio_in;
	endtask

	// --------------------
	// stimulus
	// --------------------
	task automatic drive_random();
		int unsigned kind;
		kind    = $urandom % 8;
		wb_adr  = wb_adr_t'($urandom % 16);
		wb_sel  = 4'($urandom % 16);
		gpio_in = port_t'($urandom);
		wb_stb  = (kind >= 2);
		wb_we   = (kind >= 5);
		wb_dat_w = $urandom;
		// short periods so the timer wraps often
		if (wb_adr == {PERIPH_TIMER, TMR_ADR_RELOAD}) begin
			wb_dat_w = wb_dat_t'($urandom % 12);
		end
	endtask

	task automatic check_outputs();
		compare_bit("wb_ack_o", wb_ack, wb_stb);
		compare_port("gpio_oe_o", gpio_oe, m_dir);
		compare_port("gpio_o", gpio_out, m_out);
		compare_bit("irq_o", irq, m_expired && m_irq_en);
		if (wb_stb && !wb_we) begin
			compare_dat($sformatf("read of address %h", wb_adr), wb_dat_r, model_read(wb_adr));
		end
	endtask

	initial begin
		void'($urandom(SEED));
		cycle_count = 0;
		reset    = 1'b1;
		wb_adr   = '0;
		wb_dat_w = '0;
		wb_we    = 1'b0;
		wb_sel   = '0;
		wb_stb   = 1'b0;
		gpio_in  = '0;

		m_dir     = INIT_DIRECTION;
		m_out     = INIT_OUTPUT;
		m_in      = '0;
		m_enable  = 1'b0;
		m_irq_en  = 1'b0;
		m_expired = 1'b0;
		m_reload  = '0;
		m_count   = '0;

		repeat (RESET_CYCLES) @(posedge clk);
		#1 reset = 1'b0;

		// reset values before any write
		@(negedge clk);
		compare_port("gpio_oe_o after reset", gpio_oe, INIT_DIRECTION);
		compare_port("gpio_o after reset", gpio_out, INIT_OUTPUT);
		compare_bit("irq_o after reset", irq, 1'b0);
		@(posedge clk);
		step_model();
		#1;

		for (int i = 0; i < NUM_CYCLES; i++) begin
			drive_random();
			@(negedge clk);
			check_outputs();
			@(posedge clk);
			step_model();
			#1;
		end

		$display("TESTS PASSED");
		$finish;
	end

endmodule

//--- tb.f
hdl/periph_pkg.sv
hdl/periph_wb_decode.sv
hdl/periph_gpio.sv
hdl/periph_timer.sv
hdl/periph_top.sv
verif/tb_periph.sv

//--- run.sh
#!/bin/sh
# build and run the peripheral testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f tb.f --top-module tb_periph -o sim_periph

out=$(./obj_dir/sim_periph || true)
echo "$out"

if echo "$out" | grep -q "TESTS PASSED"; then
	exit 0
else
	exit 1
fi
